//--- src.f
+incdir+verilog
verilog/m6502_pkg.sv
verilog/m6502_alu.sv
verilog/m6502_addr_seq.sv
verilog/m6502_cpu.sv
verilog/m6502_ram.sv
verilog/m6502_system.sv
tests/tb_m6502.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_m6502 \
   -f src.f -o sim_m6502 > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_m6502 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
   echo "No result line in sim.log"
   exit 1
fi
exit 0

//--- tests/tb_m6502.sv
`timescale 1ns/1ns
`include "m6502_settings.svh"

module tb_m6502;
   import m6502_pkg::*;

   logic        clk, reset_n, load_en, sync, inst_done;
   logic [15:0] load_addr;
   logic [7:0]  load_data;
   mem_bus_t    bus_mon;

   logic [31:0] rng;
   logic [15:0] pc_b;                    // Build address
   logic [7:0]  zp_next;
   logic [7:0]  m_a, m_x, m_y;           // Reference model registers
   logic        m_n, m_z, m_c;
   logic [15:0] ld_addr[$], exp_addr[$];
   logic [7:0]  ld_data[$], exp_data[$];
   int          bound[0:4];
   string       name[0:4];
   int          total, retired, errors, checks, test_idx, test_err, reads, cyc;
   logic        in_inst, seen_sync;

   m6502_system u_dut (
      .clk       (clk),
      .reset_n   (reset_n),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .bus_mon   (bus_mon),
      .sync      (sync),
      .inst_done (inst_done)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] v;
      v = s ^ (s << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic logic [7:0] next_byte();
      rng = xorshift(rng);
      return rng[7:0];
   endfunction

   task automatic value_mismatch(input string msg);
      $display("ERR %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic report_fault(input string msg);
      $display("Fault at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic end_test();
      $display("test %0d %s: %s, %0d errors", test_idx + 1, name[test_idx],
               (errors == test_err) ? "ok" : "failed", errors - test_err);
      test_err = errors;
      test_idx++;
   endtask

   task automatic put(input logic [15:0] addr, input logic [7:0] data);
      ld_addr.push_back(addr);
      ld_data.push_back(data);
   endtask

   task automatic emit(input logic [7:0] b);
      put(pc_b, b);
      pc_b = pc_b + 16'd1;
   endtask

   task automatic emit_word(input logic [7:0] opc, input logic [15:0] w);
      emit(opc);
      emit(w[7:0]);
      emit(w[15:8]);
   endtask

   task automatic set_nz(input logic [7:0] v);
      m_n = v[7];
      m_z = (v == 8'h00);
   endtask

   task automatic compare(input logic [7:0] v);
      logic [7:0] d;
      d = m_a - v;
      m_c = (m_a >= v);
      m_z = (m_a == v);
      m_n = d[7];
   endtask

   task automatic load_imm(input logic [7:0] opc, input logic [7:0] v);
      emit(opc);
      emit(v);
      case (opc)
         8'ha2:   m_x = v;
         8'ha0:   m_y = v;
         default: m_a = v;
      endcase
      set_nz(v);
      total++;
   endtask

   // STA in any mode; ea is where the model says the byte lands
   task automatic store(input logic [7:0] opc, input logic [15:0] operand, input logic [15:0] ea);
      if (opc inside {8'h8d, 8'h9d, 8'h99})
         emit_word(opc, operand);
      else
      begin
         emit(opc);
         emit(operand[7:0]);
      end
      exp_addr.push_back(ea);
      exp_data.push_back(m_a);
      total++;
   endtask

   task automatic alu_mem(input logic [2:0] aaa, input logic [2:0] bbb);
      logic [7:0]  v, t, rx;
      logic [15:0] ea;
      v = next_byte();
      t = zp_next;
      zp_next = zp_next + 8'd1;
      ea = (bbb == 3'b011) ? {4'h4, v[3:0], t} : {8'h00, t};
      put(ea, v);
      if (bbb == 3'b101)
      begin
         rx = next_byte();
         load_imm(8'ha2, rx);
         emit({aaa, bbb, 2'b01});
         emit(t - m_x);                  // Often wraps past 8'hff
      end
      else if (bbb == 3'b011)
         emit_word({aaa, bbb, 2'b01}, ea);
      else
      begin
         emit({aaa, bbb, 2'b01});
         emit(t);
      end
      if (aaa == 3'b110)
         compare(v);
      else
      begin
         m_a = (aaa == 3'b000) ? (m_a | v) : (m_a & v);
         set_nz(m_a);
      end
      total++;
   endtask

   task automatic build_program();
      logic [7:0]  r, p, opc;
      logic [15:0] ea, base, nt, tk;
      logic        flag;
      pc_b = 16'h0400;
      put(`M6502_RESET_VECTOR, pc_b[7:0]);
      put(`M6502_RESET_VECTOR + 16'd1, pc_b[15:8]);
      load_imm(8'ha9, next_byte());
      store(8'h8d, 16'h6000, 16'h6000);
      load_imm(8'ha2, next_byte());
      store(8'h8d, 16'h6001, 16'h6001);
      load_imm(8'ha0, next_byte());
      store(8'h8d, 16'h6002, 16'h6002);
      bound[1] = total;
      for (int o = 0; o < 3; o++)
         for (int m = 0; m < 3; m++)
         begin
            alu_mem((o == 0) ? 3'b000 : (o == 1) ? 3'b001 : 3'b110,
                    (m == 0) ? 3'b001 : (m == 1) ? 3'b101 : 3'b011);
            ea = 16'h6100 + 16'(o * 3 + m);
            store(8'h8d, ea, ea);
         end
      bound[2] = total;
      r = next_byte();
      load_imm(8'ha2, r);
      ea = {8'h50, next_byte()};
      store(8'h9d, ea - {8'h00, m_x}, ea);
      r = next_byte();
      load_imm(8'ha0, r);
      ea = {8'h51, next_byte()};
      store(8'h99, ea - {8'h00, m_y}, ea);
      r = next_byte();
      load_imm(8'ha2, r);
      p = zp_next;
      zp_next = zp_next + 8'd2;
      ea = {8'h52, next_byte()};
      put({8'h00, p}, ea[7:0]);
      put({8'h00, p + 8'd1}, ea[15:8]);
      store(8'h81, {8'h00, p - m_x}, ea);
      r = next_byte();
      load_imm(8'ha0, r);
      ea = {8'h53, next_byte()};
      base = ea - {8'h00, m_y};
      put(16'h00ff, base[7:0]);          // Pointer high byte wraps to 8'h00
      put(16'h0000, base[15:8]);
      store(8'h91, 16'h00ff, ea);
      bound[3] = total;
      // Bxx over the not-taken marker, BVC over the taken one
      for (int i = 0; i < 16; i++)
      begin
         opc = {i[2:0], 5'b10000};
         r = next_byte();
         if (i[3])
         begin
            emit(8'hc9);
            emit(r);
            compare(r);
            total++;
         end
         else
            load_imm(8'ha9, r);
         case (opc[7:6])
            2'b00:   flag = m_n;
            2'b01:   flag = 1'b0;
            2'b10:   flag = m_c;
            default: flag = m_z;
         endcase
         nt = 16'h0300 + 16'(2 * i);
         tk = nt + 16'd1;
         emit(opc);
         emit(8'h05);
         emit_word(8'h8d, nt);
         emit(8'h50);
         emit(8'h03);
         emit_word(8'h8d, tk);
         exp_addr.push_back((flag == opc[5]) ? tk : nt);
         exp_data.push_back(m_a);
         total += (flag == opc[5]) ? 2 : 3;
      end
      bound[4] = total;
      repeat (4) emit(8'hea);           // NOPs past the end
   endtask

   always @(posedge clk)
   begin
      cyc++;
      if (!reset_n)
      begin
         if (cyc > 1)
            assert (!bus_mon.rd_req && !bus_mon.wr_en && !sync && !inst_done)
               else report_fault("bus activity while reset is held");
      end
      else
      begin
         checks++;
         assert (!(bus_mon.rd_req && bus_mon.wr_en))
            else report_fault("rd_req and wr_en high together");
         if (bus_mon.rd_req && reads < 2)
         begin
            checks++;
            assert (bus_mon.addr == `M6502_RESET_VECTOR + 16'(reads))
               else value_mismatch($sformatf("vector read %0d at %h", reads, bus_mon.addr));
            reads++;
         end
         if (inst_done)
         begin
            assert (in_inst) else report_fault("inst_done without an open sync");
            in_inst = 1'b0;
            retired++;
            if (test_idx < 5 && retired == bound[test_idx])
               end_test();
         end
         if (sync)
         begin
            assert (!in_inst) else report_fault("second sync before inst_done");
            in_inst = 1'b1;
            if (!seen_sync)
            begin
               checks++;
               assert (bus_mon.addr == 16'h0400)
                  else value_mismatch($sformatf("first opcode read at %h", bus_mon.addr));
               seen_sync = 1'b1;
               end_test();
            end
         end
         if (bus_mon.wr_en)
         begin
            checks++;
            if (exp_addr.size() == 0)
               report_fault("write with no store expected");
            else
            begin
               assert (bus_mon.addr == exp_addr[0] && bus_mon.wr_data == exp_data[0])
                  else value_mismatch($sformatf("write %h=%h, expected %h=%h", bus_mon.addr,
                                                bus_mon.wr_data, exp_addr[0], exp_data[0]));
               exp_addr.delete(0);
               exp_data.delete(0);
            end
         end
      end
   end

   initial
   begin
      clk = 1'b0;
      reset_n = 1'b0;
      load_en = 1'b0;
      load_addr = 16'h0000;
      load_data = 8'h00;
      rng = 32'hdbe0;
      zp_next = 8'h10;
      {m_a, m_x, m_y} = '0;
      {m_n, m_z, m_c} = '0;
      {total, retired, errors, checks, test_idx, test_err, reads, cyc} = '0;
      in_inst = 1'b0;
      seen_sync = 1'b0;
      name = '{"reset_vector", "load_store", "logic_compare", "indexed_store", "branches"};
      bound[0] = -1;
      build_program();
      foreach (ld_addr[i])
      begin
         @(posedge clk);
         #1;
         load_en = 1'b1;
         load_addr = ld_addr[i];
         load_data = ld_data[i];
      end
      @(posedge clk);
      #1 load_en = 1'b0;
      repeat (3) @(posedge clk);         // Reset held 3 cycles past the load
      #1 reset_n = 1'b1;
      wait (retired == total);
      repeat (2) @(posedge clk);
      checks++;
      assert (exp_addr.size() == 0)
         else report_fault($sformatf("%0d expected writes never seen", exp_addr.size()));
      $display("tests=%0d checks=%0d errors=%0d", test_idx, checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      wait (reset_n === 1'b1);
      repeat ((total + 1) * 20) @(posedge clk);
      $display("Timeout: only %0d of %0d instructions retired", retired, total);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- verilog/m6502_system.sv
`timescale 1ns/1ns

module m6502_system (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 load_en,
   input  logic [15:0]          load_addr,
   input  logic [7:0]           load_data,
   output m6502_pkg::mem_bus_t  bus_mon,
   output logic                 sync,
   output logic                 inst_done
);
   logic [7:0] rd_data;
   logic       ready;

   m6502_cpu u_cpu (
      .clk       (clk),
      .reset_n   (reset_n),
      .rd_data   (rd_data),
      .ready     (ready),
      .bus       (bus_mon),
      .sync      (sync),
      .inst_done (inst_done)
   );

   m6502_ram u_ram (
      .clk       (clk),
      .reset_n   (reset_n),
      .bus       (bus_mon),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_data   (rd_data),
      .ready     (ready)
   );

endmodule

//--- verilog/m6502_ram.sv
`timescale 1ns/1ns
`include "m6502_settings.svh"

module m6502_ram (
   input  logic                 clk,
   input  logic                 reset_n,
   input  m6502_pkg::mem_bus_t  bus,
   input  logic                 load_en,
   input  logic [15:0]          load_addr,
   input  logic [7:0]           load_data,
   output logic [7:0]           rd_data,
   output logic                 ready
);
   localparam int WAIT_W = $clog2(`M6502_RAM_WAIT + 1);

   logic [7:0]        mem [0:65535];
   logic [15:0]       rd_addr;
   logic [WAIT_W-1:0] wait_cnt;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         ready    <= 1'b1;
         wait_cnt <= '0;
      end
      else if (bus.rd_req)
      begin
         ready    <= 1'b0;
         wait_cnt <= WAIT_W'(`M6502_RAM_WAIT);
      end
      else if (wait_cnt != '0)
      begin
         wait_cnt <= wait_cnt - 1'b1;
         if (wait_cnt == WAIT_W'(1))
            ready <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (load_en)
         mem[load_addr] <= load_data;
      else if (bus.wr_en)
         mem[bus.addr] <= bus.wr_data;
      if (bus.rd_req)
         rd_addr <= bus.addr;
      if (wait_cnt == WAIT_W'(1))
         rd_data <= mem[rd_addr];   // Byte lands as ready rises
   end

   assert property (@(posedge clk) load_en |-> !reset_n);

endmodule

//--- verilog/m6502_cpu.sv
`timescale 1ns/1ns

module m6502_cpu (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic [7:0]           rd_data,
   input  logic                 ready,
   output m6502_pkg::mem_bus_t  bus,
   output logic                 sync,
   output logic                 inst_done
);
   import m6502_pkg::*;

   typedef enum logic [2:0] {
      CPU_RESET, CPU_VECTOR, CPU_FETCH, CPU_FETCH_WAIT, CPU_DECODE, CPU_EXEC, CPU_ALU
   } cpu_state_t;

   cpu_state_t  state;
   logic [15:0] pc;
   logic [7:0]  reg_a;
   logic [7:0]  reg_x;
   logic [7:0]  reg_y;
   opcode_t     opcode;

   addr_mode_t  dec_mode;
   access_t     dec_access;
   alu_op_t     dec_op;
   logic [1:0]  inst_len;
   logic        is_branch;
   logic        flag_bit;
   logic        branch_taken;

   mem_bus_t    seq_bus;
   addr_mode_t  seq_mode;
   logic        seq_start;
   logic        seq_done;
   logic [7:0]  seq_byte;
   logic [15:0] seq_word;
   logic [15:0] operand_addr;

   logic        alu_proceed;
   logic [7:0]  alu_in_a;
   logic [7:0]  alu_result;
   flags_t      alu_flags;

   assign is_branch = (opcode.br.tail == BRANCH_TAIL);

   always_comb
   begin
      dec_mode   = MODE_IDLE;
      dec_access = ACC_LOAD;
      dec_op     = ALU_PASS;
      if (is_branch)
         dec_mode = MODE_IMM;                 // Offset byte
      else if (opcode.grp.cc == 2'b01)
      begin
         case (opcode.grp.bbb)
            3'd0: dec_mode = MODE_IND_X;
            3'd1: dec_mode = MODE_ZP;
            3'd2: dec_mode = MODE_IMM;
            3'd3: dec_mode = MODE_ABS;
            3'd4: dec_mode = MODE_IND_Y;
            3'd5: dec_mode = MODE_ZP_X;
            3'd6: dec_mode = MODE_ABS_Y;
            3'd7: dec_mode = MODE_ABS_X;
            default: dec_mode = MODE_IDLE;
         endcase
         case (opcode.grp.aaa)
            3'b000: dec_op = ALU_OR;
            3'b001: dec_op = ALU_AND;
            3'b100: dec_access = ACC_STORE;
            3'b101: dec_op = ALU_PASS;
            3'b110: dec_op = ALU_CMP;
            default: dec_mode = MODE_IDLE;   // EOR, ADC, SBC run as NOP
         endcase
         if (dec_access == ACC_STORE && dec_mode == MODE_IMM)
            dec_mode = MODE_IDLE;
      end
      else if (opcode.grp.aaa == 3'b101 && opcode.grp.bbb == 3'b000 && opcode.grp.cc != 2'b11)
         dec_mode = MODE_IMM;                 // LDY #, LDX #
   end

   assign inst_len = (dec_mode inside {MODE_ABS, MODE_ABS_X, MODE_ABS_Y}) ? 2'd3 :
                     (dec_mode == MODE_IDLE) ? 2'd1 : 2'd2;

   always_comb
   begin
      case (opcode.br.flag_sel)
         2'b00:   flag_bit = alu_flags.n;
         2'b01:   flag_bit = alu_flags.v;
         2'b10:   flag_bit = alu_flags.c;
         default: flag_bit = alu_flags.z;
      endcase
   end

   assign branch_taken = (flag_bit == opcode.br.cond);
   assign operand_addr = pc + 16'd1;
   assign seq_mode     = (state == CPU_VECTOR) ? MODE_RESET : dec_mode;
   assign sync         = (state == CPU_FETCH) && ready;
   assign alu_proceed  = (state == CPU_EXEC) && seq_done && !is_branch && dec_access == ACC_LOAD;
   assign alu_in_a     = (dec_op == ALU_PASS) ? seq_byte : reg_a;

   always_comb
   begin
      bus = seq_bus;
      if (sync)
      begin
         bus.addr   = pc;
         bus.rd_req = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      seq_start <= 1'b0;
      inst_done <= 1'b0;
      if (!reset_n)
      begin
         state  <= CPU_RESET;
         reg_a  <= 8'h00;
         reg_x  <= 8'h00;
         reg_y  <= 8'h00;
      end
      else
         case (state)
            CPU_RESET:
            begin
               seq_start <= 1'b1;
               state     <= CPU_VECTOR;
            end
            CPU_VECTOR:
               if (seq_done)
               begin
                  pc    <= seq_word;
                  state <= CPU_FETCH;
               end
            CPU_FETCH:
               if (ready)
                  state <= CPU_FETCH_WAIT;
            CPU_FETCH_WAIT:
               if (ready)
               begin
                  opcode <= rd_data;
                  state  <= CPU_DECODE;
               end
            CPU_DECODE:
               if (dec_mode == MODE_IDLE)
               begin
                  pc        <= pc + 16'd1;
                  inst_done <= 1'b1;
                  state     <= CPU_FETCH;
               end
               else
               begin
                  seq_start <= 1'b1;
                  state     <= CPU_EXEC;
               end
            CPU_EXEC:
               if (seq_done)
               begin
                  if (is_branch)
                  begin
                     pc <= pc + 16'd2 + (branch_taken ? {{8{seq_byte[7]}}, seq_byte} : 16'h0000);
                     inst_done <= 1'b1;
                     state     <= CPU_FETCH;
                  end
                  else if (dec_access == ACC_STORE)
                  begin
                     pc        <= pc + {14'd0, inst_len};
                     inst_done <= 1'b1;
                     state     <= CPU_FETCH;
                  end
                  else
                     state <= CPU_ALU;
               end
            CPU_ALU:
            begin
               if (opcode.grp.cc == 2'b10)
                  reg_x <= alu_result;
               else if (opcode.grp.cc == 2'b00)
                  reg_y <= alu_result;
               else if (dec_op != ALU_CMP)
                  reg_a <= alu_result;
               pc        <= pc + {14'd0, inst_len};
               inst_done <= 1'b1;
               state     <= CPU_FETCH;
            end
            default:
               state <= CPU_RESET;
         endcase
   end

   m6502_alu u_alu (
      .clk     (clk),
      .reset_n (reset_n),
      .proceed (alu_proceed),
      .op      (dec_op),
      .in_a    (alu_in_a),
      .in_b    (seq_byte),
      .result  (alu_result),
      .flags   (alu_flags)
   );

   m6502_addr_seq u_addr_seq (
      .clk          (clk),
      .reset_n      (reset_n),
      .start        (seq_start),
      .mode         (seq_mode),
      .access       (dec_access),
      .operand_addr (operand_addr),
      .index_x      (reg_x),
      .index_y      (reg_y),
      .store_data   (reg_a),
      .rd_data      (rd_data),
      .ready        (ready),
      .bus          (seq_bus),
      .done         (seq_done),
      .load_byte    (seq_byte),
      .load_word    (seq_word)
   );

   // Opcode fetch goes out on an idle bus
   assert property (@(posedge clk) disable iff (!reset_n)
      sync |-> !seq_bus.rd_req && !seq_bus.wr_en);

endmodule

//--- verilog/m6502_addr_seq.sv
`timescale 1ns/1ns
`include "m6502_settings.svh"

module m6502_addr_seq (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   start,
   input  m6502_pkg::addr_mode_t  mode,
   input  m6502_pkg::access_t     access,
   input  logic [15:0]            operand_addr,
   input  logic [7:0]             index_x,
   input  logic [7:0]             index_y,
   input  logic [7:0]             store_data,
   input  logic [7:0]             rd_data,
   input  logic                   ready,
   output m6502_pkg::mem_bus_t    bus,
   output logic                   done,
   output logic [7:0]             load_byte,
   output logic [15:0]            load_word
);
   import m6502_pkg::*;

   typedef enum logic [3:0] {
      S_IDLE, S_ZP, S_PTR_LO, S_PTR_HI, S_ABS_LO, S_ABS_HI, S_VEC_LO, S_VEC_HI, S_FINAL
   } seq_state_t;

   seq_state_t  state;
   addr_mode_t  mode_q;
   access_t     access_q;
   logic [7:0]  lo_q;
   logic [7:0]  zp_sum;
   logic [7:0]  ptr;
   logic [7:0]  post_index;
   logic [15:0] ea;
   logic        got_byte;
   logic        at_final;

   assign got_byte   = ready && !bus.rd_req;
   assign zp_sum     = rd_data + index_x;              // Wraps in page 0
   assign ptr        = (mode_q == MODE_IND_X) ? zp_sum : rd_data;
   assign post_index = (mode_q == MODE_ABS_X) ? index_x :
                       (mode_q inside {MODE_ABS_Y, MODE_IND_Y}) ? index_y : 8'h00;
   assign ea = (state == S_ZP) ? {8'h00, (mode_q == MODE_ZP_X) ? zp_sum : rd_data}
                               : {rd_data, lo_q} + {8'h00, post_index};
   assign at_final = got_byte && (state inside {S_PTR_HI, S_ABS_HI} ||
                     (state == S_ZP && mode_q inside {MODE_ZP, MODE_ZP_X}));

   always_ff @(posedge clk)
   begin
      bus.rd_req <= 1'b0;
      bus.wr_en  <= 1'b0;
      done       <= 1'b0;
      if (!reset_n)
         state <= S_IDLE;
      else
      begin
         case (state)
            S_IDLE:
               if (start)
               begin
                  mode_q     <= mode;
                  access_q   <= access;
                  bus.rd_req <= 1'b1;
                  bus.addr   <= (mode == MODE_RESET) ? `M6502_RESET_VECTOR : operand_addr;
                  case (mode)
                     MODE_RESET:                          state <= S_VEC_LO;
                     MODE_ABS, MODE_ABS_X, MODE_ABS_Y:    state <= S_ABS_LO;
                     MODE_ZP, MODE_ZP_X,
                     MODE_IND_X, MODE_IND_Y:              state <= S_ZP;
                     default:                             state <= S_FINAL;
                  endcase
               end
            S_ZP:
               if (got_byte && mode_q inside {MODE_IND_X, MODE_IND_Y})
               begin
                  bus.addr   <= {8'h00, ptr};
                  bus.rd_req <= 1'b1;
                  state      <= S_PTR_LO;
               end
            S_PTR_LO:
               if (got_byte)
               begin
                  lo_q       <= rd_data;
                  bus.addr   <= {8'h00, bus.addr[7:0] + 8'h01};   // Pointer wraps in page 0
                  bus.rd_req <= 1'b1;
                  state      <= S_PTR_HI;
               end
            S_ABS_LO:
               if (got_byte)
               begin
                  lo_q       <= rd_data;
                  bus.addr   <= operand_addr + 16'd1;
                  bus.rd_req <= 1'b1;
                  state      <= S_ABS_HI;
               end
            S_VEC_LO:
               if (got_byte)
               begin
                  lo_q       <= rd_data;
                  bus.addr   <= bus.addr + 16'd1;
                  bus.rd_req <= 1'b1;
                  state      <= S_VEC_HI;
               end
            S_VEC_HI:
               if (got_byte)
               begin
                  load_word <= {rd_data, lo_q};
                  done      <= 1'b1;
                  state     <= S_IDLE;
               end
            S_FINAL:
               if (got_byte)
               begin
                  load_byte <= rd_data;
                  done      <= 1'b1;
                  state     <= S_IDLE;
               end
            default:
               ;
         endcase

         if (at_final)
         begin
            bus.addr    <= ea;
            bus.wr_data <= store_data;
            if (access_q == ACC_STORE)
            begin
               bus.wr_en <= 1'b1;       // Write completes this cycle
               done      <= 1'b1;
               state     <= S_IDLE;
            end
            else
            begin
               bus.rd_req <= 1'b1;
               state      <= S_FINAL;
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (!reset_n) !(bus.rd_req && bus.wr_en));
   assert property (@(posedge clk) disable iff (!reset_n) !ready |-> !bus.rd_req && !bus.wr_en);

endmodule

//--- verilog/m6502_alu.sv
`timescale 1ns/1ns

module m6502_alu (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                proceed,
   input  m6502_pkg::alu_op_t  op,
   input  logic [7:0]          in_a,
   input  logic [7:0]          in_b,
   output logic [7:0]          result,
   output m6502_pkg::flags_t   flags
);
   import m6502_pkg::*;

   logic [7:0] logic_out;
   logic [8:0] diff;

   assign diff = {1'b0, in_a} - {1'b0, in_b};   // Bit 8 is the borrow

   always_comb
   begin
      case (op)
         ALU_OR:  logic_out = in_a | in_b;
         ALU_AND: logic_out = in_a & in_b;
         ALU_PASS,
         ALU_CMP: logic_out = in_a;
         default: logic_out = in_a;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         flags <= '0;
      else if (proceed)
      begin
         if (op == ALU_CMP)
         begin
            flags.c <= !diff[8];
            flags.z <= (diff[7:0] == 8'h00);
            flags.n <= diff[7];
         end
         else
         begin
            flags.z <= (logic_out == 8'h00);
            flags.n <= logic_out[7];
         end
         flags.v <= 1'b0;                 // No ADC/SBC
      end
   end

   always_ff @(posedge clk)
   begin
      if (proceed && op != ALU_CMP)
         result <= logic_out;
   end

   assert property (@(posedge clk) disable iff (!reset_n) proceed |=> !proceed);

endmodule

//--- verilog/m6502_pkg.sv
package m6502_pkg;

   typedef struct packed {
      logic [2:0] aaa;       // Operation
      logic [2:0] bbb;       // Addressing mode
      logic [1:0] cc;        // Group
   } op_group_t;

   typedef struct packed {
      logic [1:0] flag_sel;  // N, V, C, Z
      logic       cond;      // Taken when flag equals this
      logic [4:0] tail;
   } op_branch_t;

   typedef union packed {
      op_group_t  grp;
      op_branch_t br;
   } opcode_t;

   localparam logic [4:0] BRANCH_TAIL = 5'b10000;

   typedef enum logic [1:0] {ALU_PASS, ALU_OR, ALU_AND, ALU_CMP} alu_op_t;

   typedef enum logic [3:0] {
      MODE_IDLE, MODE_RESET, MODE_IMM,
      MODE_ZP, MODE_ZP_X,
      MODE_ABS, MODE_ABS_X, MODE_ABS_Y,
      MODE_IND_X, MODE_IND_Y
   } addr_mode_t;

   typedef enum logic {ACC_LOAD, ACC_STORE} access_t;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } flags_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        wr_en;
      logic        rd_req;
   } mem_bus_t;

endpackage

//--- verilog/m6502_settings.svh
`ifndef M6502_SETTINGS_SVH
`define M6502_SETTINGS_SVH

// Low byte of the reset vector, high byte follows
`define M6502_RESET_VECTOR 16'hfffc

// Stack pointer after reset
`define M6502_SP_RESET 8'hff

// Cycles that ready stays low after a read request
`define M6502_RAM_WAIT 1

`endif
